/* hw/dot_pkg.sv */
// --------------------
// Dot-product types and constants
// Element, product, sum and accumulator types shared by the datapath
// --------------------
package dot_pkg;

   // --------------------
   // Vector geometry
   // --------------------

   // Width of one signed element
   localparam int DATA_W = 4;

   // Elements per input vector and per 16-element slice
   localparam int VEC_LEN   = 64;
   localparam int SLICE_LEN = 16;
   localparam int SLICES    = VEC_LEN / SLICE_LEN;

   // Accumulator and saturated result width
   localparam int ACC_W = 8;

   // --------------------
   // Datapath types
   // --------------------

   typedef logic signed [DATA_W-1:0] elem_t;

   // A 4x4 signed product needs twice the element width
   typedef logic signed [2*DATA_W-1:0] prod_t;

   // Sixteen products grow the sum by four bits, sixty-four by six
   typedef logic signed [2*DATA_W+3:0] psum_t;
   typedef logic signed [2*DATA_W+5:0] sum_t;

   typedef logic signed [ACC_W-1:0] acc_t;

   // Element 0 sits in the least significant bits
   typedef elem_t [VEC_LEN-1:0]   vec_t;
   typedef elem_t [SLICE_LEN-1:0] slice_t;

endpackage

/* hw/dot_lane_if.sv */
// --------------------
// Slice lane between dot64_mac and one dot16
// Carries a 16-element a and b slice down and the partial sum back up
// --------------------
interface dot_lane_if;
   import dot_pkg::*;

   // Operand slices, already aligned by the input stage
   slice_t a;
   slice_t b;

   // Clock enable for every register in the lane
   logic   ena;

   // Registered 16-element partial sum
   psum_t  psum;

   // Side of the parent that splits the vectors
   modport src (output a, output b, output ena, input psum);

   // Side of the dot16 slice
   modport sink (input a, input b, input ena, output psum);

endinterface

/* hw/delay_line.sv */
// --------------------
// Enabled register chain
// DEPTH stages over any payload type, DEPTH 0 gives a plain wire
// --------------------
module delay_line #(
   parameter type T     = logic,
   parameter int  DEPTH = 1
) (
   input  logic clk,
   input  logic rst,
   input  logic ena,
   input  T     d,
   output T     q
);

   generate
      if (DEPTH == 0) begin : g_wire
         // No stages requested so the payload passes straight through
         assign q = d;
      end else begin : g_regs
         T stage [DEPTH];

         // The whole chain shifts by one on every enabled edge
         always_ff @(posedge clk) begin
            if (rst) begin
               for (int i = 0; i < DEPTH; i++) begin
                  stage[i] <= '0;
               end
            end else if (ena) begin
               stage[0] <= d;
               for (int i = 1; i < DEPTH; i++) begin
                  stage[i] <= stage[i-1];
               end
            end
         end

         assign q = stage[DEPTH-1];
      end
   endgenerate

endmodule

/* hw/dot16.sv */
// --------------------
// Pipelined 16-element dot product
// Signed 4x4 multipliers followed by a four-level adder tree
// --------------------
module dot16 #(
   parameter int MULT_LATENCY = 3,
   parameter int TREE_DELAY   = 1
) (
   input  logic           clk,
   input  logic           rst,
   dot_lane_if.sink       lane
);
   import dot_pkg::*;

   // Node counts of the reduction levels
   localparam int LVL1_N = SLICE_LEN / 2;
   localparam int LVL2_N = SLICE_LEN / 4;
   localparam int LVL3_N = SLICE_LEN / 8;

   // Raw and pipelined products
   prod_t prod   [SLICE_LEN];
   prod_t prod_q [SLICE_LEN];

   // Adder tree nodes, all carried at partial-sum width
   psum_t lvl1 [LVL1_N];
   psum_t lvl2 [LVL2_N];
   psum_t lvl3 [LVL3_N];
   psum_t tree_sum;

   // --------------------
   // Multiplier stage
   // --------------------

   // Each product is formed combinationally from the lane operands and then
   // carried through MULT_LATENCY registers, which a retiming tool can pull
   // back into the multiplier logic
   for (genvar i = 0; i < SLICE_LEN; i++) begin : g_mult
      // Signed operands are sign extended to the 8-bit product width
      assign prod[i] = $signed(lane.a[i]) * $signed(lane.b[i]);

      delay_line #(
         .T     (prod_t),
         .DEPTH (MULT_LATENCY)
      ) u_prod_dly (
         .clk (clk),
         .rst (rst),
         .ena (lane.ena),
         .d   (prod[i]),
         .q   (prod_q[i])
      );
   end

   // --------------------
   // Adder tree
   // --------------------

   // Four levels reduce sixteen products to one partial sum
   always_comb begin
      for (int k = 0; k < LVL1_N; k++) begin
         lvl1[k] = psum_t'(prod_q[2*k]) + psum_t'(prod_q[2*k+1]);
      end
      for (int k = 0; k < LVL2_N; k++) begin
         lvl2[k] = lvl1[2*k] + lvl1[2*k+1];
      end
      for (int k = 0; k < LVL3_N; k++) begin
         lvl3[k] = lvl2[2*k] + lvl2[2*k+1];
      end
      // Worst case is sixteen times 64, well inside the 12-bit range
      tree_sum = lvl3[0] + lvl3[1];
   end

   // The tree output is registered before it leaves the slice
   delay_line #(
      .T     (psum_t),
      .DEPTH (TREE_DELAY)
   ) u_tree_dly (
      .clk (clk),
      .rst (rst),
      .ena (lane.ena),
      .d   (tree_sum),
      .q   (lane.psum)
   );

endmodule

/* hw/dot64_mac.sv */
// --------------------
// 64-element signed dot product with accumulate
// Four dot16 slices, a two-level sum and a saturated 8-bit result
// --------------------
module dot64_mac #(
   parameter int MULT_LATENCY = 3,
   parameter int TREE_DELAY   = 1,
   parameter int INPUT_DELAY  = 1,
   parameter int OUT_DELAY    = 1
) (
   input  logic           clk,
   input  logic           rst,
   input  logic           ena,
   input  dot_pkg::vec_t  a_in,
   input  dot_pkg::vec_t  b_in,
   input  dot_pkg::acc_t  acc_in,
   output dot_pkg::acc_t  result
);
   import dot_pkg::*;

   // Enabled cycles from the input sample to the registers feeding result
   localparam int L = INPUT_DELAY + MULT_LATENCY + TREE_DELAY + 2 * OUT_DELAY;

   // The final add needs one bit more than the 64-element sum
   localparam int TOTAL_W = $bits(sum_t) + 1;
   localparam int PAIRS   = SLICES / 2;

   typedef logic signed [TOTAL_W-1:0] total_t;

   // Saturation bounds of the 8-bit signed result
   localparam total_t SAT_HI = total_t'(2 ** (ACC_W - 1) - 1);
   localparam total_t SAT_LO = total_t'(-(2 ** (ACC_W - 1)));

   vec_t   a_q;
   vec_t   b_q;
   psum_t  psum     [SLICES];
   sum_t   pair_sum [PAIRS];
   sum_t   pair_q   [PAIRS];
   sum_t   sum_d;
   sum_t   sum_q;
   acc_t   acc_q;
   total_t total;

   // --------------------
   // Input stage
   // --------------------
   delay_line #(.T(vec_t), .DEPTH(INPUT_DELAY)) u_a_dly (
      .clk (clk), .rst (rst), .ena (ena), .d (a_in), .q (a_q)
   );
   delay_line #(.T(vec_t), .DEPTH(INPUT_DELAY)) u_b_dly (
      .clk (clk), .rst (rst), .ena (ena), .d (b_in), .q (b_q)
   );

   // Each slice gets its own lane and the shared enable
   for (genvar s = 0; s < SLICES; s++) begin : g_slice
      dot_lane_if lane ();

      assign lane.a   = a_q[s*SLICE_LEN +: SLICE_LEN];
      assign lane.b   = b_q[s*SLICE_LEN +: SLICE_LEN];
      assign lane.ena = ena;

      dot16 #(
         .MULT_LATENCY (MULT_LATENCY),
         .TREE_DELAY   (TREE_DELAY)
      ) u_dot16 (
         .clk  (clk),
         .rst  (rst),
         .lane (lane.sink)
      );

      assign psum[s] = lane.psum;
   end

   // --------------------
   // Sum levels
   // --------------------

   // Neighbouring slices are added in pairs first
   for (genvar p = 0; p < PAIRS; p++) begin : g_pair
      assign pair_sum[p] = sum_t'(psum[2*p]) + sum_t'(psum[2*p+1]);

      delay_line #(.T(sum_t), .DEPTH(OUT_DELAY)) u_pair_dly (
         .clk (clk), .rst (rst), .ena (ena), .d (pair_sum[p]), .q (pair_q[p])
      );
   end

   // Second level joins the two pair sums into the full 64-element sum
   assign sum_d = pair_q[0] + pair_q[1];

   delay_line #(.T(sum_t), .DEPTH(OUT_DELAY)) u_sum_dly (
      .clk (clk), .rst (rst), .ena (ena), .d (sum_d), .q (sum_q)
   );

   // The accumulator value travels alongside the whole datapath
   delay_line #(.T(acc_t), .DEPTH(L)) u_acc_dly (
      .clk (clk), .rst (rst), .ena (ena), .d (acc_in), .q (acc_q)
   );

   // --------------------
   // Accumulate and saturate
   // --------------------
   assign total = total_t'(sum_q) + total_t'(acc_q);

   // Clamp to the signed 8-bit range, otherwise pass the low bits
   always_comb begin
      if (total > SAT_HI) begin
         result = acc_t'(SAT_HI);
      end else if (total < SAT_LO) begin
         result = acc_t'(SAT_LO);
      end else begin
         result = acc_t'(total);
      end
   end

endmodule

/* hw/dot_rows.sv */
// --------------------
// Matrix-vector row array
// ROWS dot64_mac rows that share one b vector
// --------------------
module dot_rows #(
   parameter int ROWS         = 2,
   parameter int MULT_LATENCY = 3,
   parameter int TREE_DELAY   = 1,
   parameter int INPUT_DELAY  = 1,
   parameter int OUT_DELAY    = 1
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           ena,
   // One a vector and one accumulator value per row
   input  dot_pkg::vec_t [ROWS-1:0]       a_in,
   // Shared b vector
   input  dot_pkg::vec_t                  b_in,
   input  dot_pkg::acc_t [ROWS-1:0]       acc_in,
   // Saturated result per row
   output dot_pkg::acc_t [ROWS-1:0]       result
);

   // Every row runs the same pipeline so all results line up in time
   for (genvar r = 0; r < ROWS; r++) begin : g_row
      dot64_mac #(
         .MULT_LATENCY (MULT_LATENCY),
         .TREE_DELAY   (TREE_DELAY),
         .INPUT_DELAY  (INPUT_DELAY),
         .OUT_DELAY    (OUT_DELAY)
      ) u_row (
         .clk    (clk),
         .rst    (rst),
         .ena    (ena),
         .a_in   (a_in[r]),
         .b_in   (b_in),
         .acc_in (acc_in[r]),
         .result (result[r])
      );
   end

endmodule

/* tests/dot_rows_assert.sv */
// --------------------
// Reset and stall checks for dot64_mac
// Bound into every row of the design
// --------------------
module dot_rows_assert (
   input logic          clk,
   input logic          rst,
   input logic          ena,
   input dot_pkg::acc_t result
);
   timeunit 1ns;
   timeprecision 100ps;

   // Every register clears, so the output settles to zero one edge later
   property p_reset_clears;
      @(posedge clk) rst |=> (result == '0);
   endproperty

   // A stalled edge moves no register, so the output cannot move either
   property p_stall_holds;
      @(posedge clk) disable iff (rst) !ena |=> $stable(result);
   endproperty

   a_reset_clears: assert property (p_reset_clears)
      else $error("result is not zero in the cycle after reset");

   a_stall_holds: assert property (p_stall_holds)
      else $error("result changed across an edge with ena low");

endmodule

bind dot64_mac dot_rows_assert u_assert (
   .clk    (clk),
   .rst    (rst),
   .ena    (ena),
   .result (result)
);

/* tests/dot_rows_tb.sv */
// --------------------
// Testbench for dot_rows
// Replays the vector file under random stalls and checks both rows
// --------------------
module dot_rows_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import dot_pkg::*;

   localparam int ROWS = 2;
   // Enabled cycles from input sample to result, with the default DUT parameters
   localparam int L = 1 + 3 + 1 + 2 * 1;

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 ena;
   vec_t [ROWS-1:0]      a_in;
   vec_t                 b_in;
   acc_t [ROWS-1:0]      acc_in;
   acc_t [ROWS-1:0]      result;

   // Vector file contents, one entry per data line
   string name_q [$];
   vec_t  a0_q [$];
   vec_t  a1_q [$];
   vec_t  b_q [$];
   acc_t  acc0_q [$];
   acc_t  acc1_q [$];
   acc_t  exp0_q [$];
   acc_t  exp1_q [$];

   // Lines in flight and the enabled-edge count when each was applied
   int flight_idx [$];
   int flight_stamp [$];

   integer seed = 32'h9c26fd9a;
   int     n_lines = 0;
   int     next_line = 0;
   int     n_checked = 0;
   int     en_count = 0;
   int     cycles = 0;
   int     cycle_limit = 0;
   string  cur_name = "fill";
   acc_t   cur_exp [ROWS];

   dot_rows UUT (
      .clk    (clk),
      .rst    (rst),
      .ena    (ena),
      .a_in   (a_in),
      .b_in   (b_in),
      .acc_in (acc_in),
      .result (result)
   );

   always #5 clk = ~clk;

   // --------------------
   // Timeout
   // --------------------
   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("*** TEST FAILED ***");
         $fatal(1, "Timeout after %0d cycles with %0d of %0d lines checked",
                cycles, n_checked, n_lines);
      end
   end

   // Compare one row result against its expected saturated value
   task automatic check_acc(input string test_name, input acc_t expected, input acc_t actual);
      if (actual !== expected) begin
         $display("Error: test %0s expected %0d actual %0d", test_name, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1, "Result mismatch");
      end
   endtask

   // Read every data line of the vector file into the queues
   task automatic load_vectors();
      int                fd;
      int                n;
      logic [8*320-1:0]  text;
      logic [8*24-1:0]   name_buf;
      vec_t              a0, a1, b;
      acc_t              c0, c1, e0, e1;
      fd = $fopen("tests/dot_rows_golden.txt", "r");
      if (fd == 0) begin
         $display("*** TEST FAILED ***");
         $fatal(1, "Could not open the vector file");
      end
      while (!$feof(fd)) begin
         text = '0;
         if ($fgets(text, fd) > 0) begin
            // Comment and blank lines do not yield all eight fields
            n = $sscanf(text, "%s %h %h %h %h %h %h %h",
                        name_buf, a0, a1, b, c0, c1, e0, e1);
            if (n == 8) begin
               name_q.push_back(string'(name_buf));
               a0_q.push_back(a0);
               a1_q.push_back(a1);
               b_q.push_back(b);
               acc0_q.push_back(c0);
               acc1_q.push_back(c1);
               exp0_q.push_back(e0);
               exp1_q.push_back(e1);
            end
         end
      end
      $fclose(fd);
      n_lines = name_q.size();
   endtask

   // Pick the enable for the next edge and drive the matching inputs
   task automatic apply_inputs();
      ena = (($random(seed) & 3) != 0);
      if (ena && next_line < n_lines) begin
         a_in[0]   = a0_q[next_line];
         a_in[1]   = a1_q[next_line];
         b_in      = b_q[next_line];
         acc_in[0] = acc0_q[next_line];
         acc_in[1] = acc1_q[next_line];
         flight_idx.push_back(next_line);
         flight_stamp.push_back(en_count);
         next_line++;
      end else if (ena) begin
         // Out of lines, so zeros follow the last one down the pipe
         a_in   = '0;
         b_in   = '0;
         acc_in = '0;
      end else begin
         // Stalled edges must ignore whatever sits on the inputs
         a_in   = ~a_in;
         b_in   = ~b_in;
         acc_in = ~acc_in;
      end
   endtask

   // Count the edge just passed and retire the oldest line once it is due
   task automatic retire_line();
      int idx;
      if (ena) begin
         en_count++;
      end
      if (flight_idx.size() > 0 && en_count - flight_stamp[0] == L) begin
         idx = flight_idx.pop_front();
         void'(flight_stamp.pop_front());
         cur_name   = name_q[idx];
         cur_exp[0] = exp0_q[idx];
         cur_exp[1] = exp1_q[idx];
         n_checked++;
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      rst    = 1'b1;
      ena    = 1'b0;
      a_in   = '0;
      b_in   = '0;
      acc_in = '0;
      cur_exp[0] = '0;
      cur_exp[1] = '0;
      load_vectors();
      cycle_limit = 4 * (n_lines + L) + 40;

      // Result must read zero for every cycle of reset
      repeat (8) begin
         @(negedge clk);
         for (int r = 0; r < ROWS; r++) begin
            check_acc("reset", '0, result[r]);
         end
      end
      rst = 1'b0;
      apply_inputs();

      // Result only ever shows the newest retired line, or zero before the first
      while (n_checked < n_lines) begin
         @(negedge clk);
         retire_line();
         check_acc(cur_name, cur_exp[0], result[0]);
         check_acc(cur_name, cur_exp[1], result[1]);
         apply_inputs();
      end

      if (n_lines > 0 && n_checked == n_lines) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         $display("*** TEST FAILED ***");
         $fatal(1, "No test vectors were found in the vector file");
      end
   end

endmodule

/* tests/dot_rows_golden.txt */
# name a0 a1 b acc0 acc1 result0 result1
# vectors are 64 hex digits with element 0 last, all values in hex
zero 0000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000 00 00 00 00
one_per_slice 0000000000000001000000000000000100000000000000010000000000000001 0000000000000003000000000000000300000000000000030000000000000003 2222222222222222222222222222222222222222222222222222222222222222 00 00 08 18
sat_high_low 8888888888888888888888888888888888888888888888888888888888888888 7777777777777777777777777777777777777777777777777777777777777777 8888888888888888888888888888888888888888888888888888888888888888 00 00 7f 80
acc_pull_back 1111111111111111111111111111111111111111111111111111111111111111 1111111111111111111111111111111111111111111111111111111111111111 2222222222222222222222222222222222222222222222222222222222222222 f6 80 76 00
acc_push_over 0000000000000001000000000000000100000000000000010000000000000001 0000000000000003000000000000000300000000000000030000000000000003 2222222222222222222222222222222222222222222222222222222222222222 7c 64 7f 7c
acc_push_under 0000000000000001000000000000000100000000000000010000000000000001 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 80 c0 80 00
rows_split 2222222222222222222222222222222222222222222222222222222222222222 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000003000000000000000300000000000000030000000000000003 05 0a 1d fe
alternating 0101010101010101010101010101010101010101010101010101010101010101 1010101010101010101010101010101010101010101010101010101010101010 7777777777777777777777777777777777777777777777777777777777777777 90 9c 70 7c
neg_sum ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0000000000000000000000000000000000000000000000000000000000000000 1111111111111111111111111111111111111111111111111111111111111111 f0 33 b0 33
top_element 7000000000000000000000000000000000000000000000000000000000000000 1111111111111111111111111111111111111111111111111111111111111111 f111111111111111111111111111111111111111111111111111111111111111 00 00 f9 3e
near_limit 8888888888888888888888888888888888888888888888888888888888888888 0000000000000001000000000000000100000000000000010000000000000001 1111111111111111111111111111111111111111111111111111111111111111 7f 7b 80 7f
acc_only 0000000000000000000000000000000000000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000 5555555555555555555555555555555555555555555555555555555555555555 12 ed 12 ed
deep_sat 7777777777777777777777777777777777777777777777777777777777777777 8888888888888888888888888888888888888888888888888888888888888888 7777777777777777777777777777777777777777777777777777777777777777 80 7f 7f 80
small_neg 0000000000000001000000000000000100000000000000010000000000000001 0000000000000003000000000000000300000000000000030000000000000003 8888888888888888888888888888888888888888888888888888888888888888 20 10 00 b0

/* tb.f */
hw/dot_pkg.sv
hw/dot_lane_if.sv
hw/delay_line.sv
hw/dot16.sv
hw/dot64_mac.sv
hw/dot_rows.sv
tests/dot_rows_assert.sv
tests/dot_rows_tb.sv

/* Makefile */
# Verilator simulation of the dot_rows testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module dot_rows_tb -f tb.f -o sim_dot_rows

run: compile
	./obj_dir/sim_dot_rows | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
